/* src.f */
+incdir+hw
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_alu.sv
hw/rv_branch_unit.sv
hw/rv_exec_core.sv
bench/tb_exec_core.sv

/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary -f src.f --top-module tb_exec_core -o sim_exec_core
	out="$$(./obj_dir/sim_exec_core)"; echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module tb_exec_core

clean:
	rm -rf obj_dir

/* bench/tb_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module tb_exec_core;

    localparam int MODE_ZERO   = 0;
    localparam int MODE_ALU    = 1;
    localparam int MODE_CTRL   = 2;
    localparam int MODE_MEM    = 3;
    localparam int MODE_ALL    = 4;
    localparam int TOTAL_INSTR = 1232;
    localparam int CYCLE_LIMIT = 20 * TOTAL_INSTR;

    logic                I_clk;
    logic                rst;
    logic                in_valid;
    logic                in_ready;
    logic [31:0]         in_instr;
    logic [31:0]         in_pc;
    logic                out_valid;
    logic                out_ready;
    logic [4:0]          out_rd;
    logic                out_we;
    logic [31:0]         out_wdata;
    logic [31:0]         out_next_pc;
    rv_pkg::mem_op_e     out_mem_op;
    logic [31:0]         out_addr;
    logic [31:0]         out_sdata;

    logic [31:0] model_regs [32];
    logic [31:0] instr_q [$];
    logic [31:0] pc_q [$];
    int          test_errors;
    int          total_errors;
    int          failed_tests;
    int          run_tests;
    int          cycles;

    rv_exec_core u_dut (
        .I_clk       (I_clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_instr    (in_instr),
        .in_pc       (in_pc),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_rd      (out_rd),
        .out_we      (out_we),
        .out_wdata   (out_wdata),
        .out_next_pc (out_next_pc),
        .out_mem_op  (out_mem_op),
        .out_addr    (out_addr),
        .out_sdata   (out_sdata)
    );

    initial begin
        I_clk = 1'b0;
        forever #10 I_clk = ~I_clk;
    end

    // Run limit scales with the instruction count
    initial cycles = 0;
    always @(posedge I_clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: no progress after %0d cycles, pipeline looks stuck", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input string field,
                              input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s %s expected %h actual %h", name, field, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_mem(input string name, input rv_pkg::mem_op_e exp,
                             input rv_pkg::mem_op_e act);
        if (exp !== act) begin
            $display("FAIL %s mem_op expected %s actual %s", name, exp.name(), act.name());
            test_errors++;
        end
    endtask

    // rd only matters when the instruction writes
    task automatic check_reg(input string name, input logic [4:0] exp_rd, input logic exp_we,
                             input logic [4:0] act_rd, input logic act_we);
        if (exp_we !== act_we || (exp_we && exp_rd !== act_rd)) begin
            $display("FAIL %s rd/we expected x%0d/%b actual x%0d/%b",
                     name, exp_rd, exp_we, act_rd, act_we);
            test_errors++;
        end
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA model that updates its own register file in program order
    task automatic run_model(input logic [31:0] ins, input logic [31:0] pc,
                             output logic [4:0] e_rd, output logic e_we,
                             output logic [31:0] e_wdata, output logic [31:0] e_npc,
                             output rv_pkg::mem_op_e e_mem, output logic [31:0] e_addr,
                             output logic [31:0] e_sdata);
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic        taken;
        f3    = ins[14:12];
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        e_rd    = ins[11:7];
        e_we    = 1'b0;
        e_wdata = 32'd0;
        e_npc   = pc + 32'd4;
        e_mem   = rv_pkg::mem_none;
        e_addr  = 32'd0;
        e_sdata = 32'd0;
        taken   = 1'b0;
        case (ins[6:2])
            `RV_OP_OP: begin
                e_we    = 1'b1;
                e_wdata = alu_ref(f3, ins[30], a, b);
            end
            `RV_OP_OPIMM: begin
                e_we    = 1'b1;
                e_wdata = alu_ref(f3, ins[30] && f3 == 3'b101, a, imm_i);
            end
            `RV_OP_LUI: begin
                e_we    = 1'b1;
                e_wdata = {ins[31:12], 12'd0};
            end
            `RV_OP_AUIPC: begin
                e_we    = 1'b1;
                e_wdata = pc + {ins[31:12], 12'd0};
            end
            `RV_OP_JAL: begin
                e_we    = 1'b1;
                e_wdata = pc + 32'd4;
                e_npc   = pc + imm_j;
            end
            `RV_OP_JALR: begin
                e_we    = 1'b1;
                e_wdata = pc + 32'd4;
                e_npc   = (a + imm_i) & ~32'd1;
            end
            `RV_OP_BRANCH: begin
                case (f3)
                    `RV_F3_BEQ:  taken = (a == b);
                    `RV_F3_BNE:  taken = (a != b);
                    `RV_F3_BLT:  taken = ($signed(a) < $signed(b));
                    `RV_F3_BGE:  taken = ($signed(a) >= $signed(b));
                    `RV_F3_BLTU: taken = (a < b);
                    default:     taken = (a >= b);
                endcase
                if (taken) begin
                    e_npc = pc + imm_b;
                end
            end
            `RV_OP_LOAD: begin
                e_addr = a + imm_i;
                case (f3)
                    `RV_F3_LB:  e_mem = rv_pkg::mem_rb;
                    `RV_F3_LH:  e_mem = rv_pkg::mem_rh;
                    `RV_F3_LW:  e_mem = rv_pkg::mem_rw;
                    `RV_F3_LBU: e_mem = rv_pkg::mem_rbu;
                    default:    e_mem = rv_pkg::mem_rhu;
                endcase
            end
            `RV_OP_STORE: begin
                e_addr  = a + imm_s;
                e_sdata = b;
                case (f3)
                    `RV_F3_SB: e_mem = rv_pkg::mem_wb;
                    `RV_F3_SH: e_mem = rv_pkg::mem_wh;
                    default:   e_mem = rv_pkg::mem_ww;
                endcase
            end
            default: e_we = 1'b0;
        endcase
        if (e_we && e_rd != 5'd0) begin
            model_regs[e_rd] = e_wdata;
        end
    endtask

    // Random legal encoding with the class picked by test mode
    function automatic logic [31:0] make_instr(input int mode, input int idx,
                                               input logic [4:0] reg_mask);
        logic [31:0] r;
        logic [31:0] k;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] i12;
        logic [19:0] u20;
        int          sel;
        r   = $urandom;
        k   = $urandom;
        rd  = r[4:0] & reg_mask;
        rs1 = r[9:5] & reg_mask;
        rs2 = r[14:10] & reg_mask;
        f3  = r[17:15];
        i12 = r[31:20];
        u20 = k[31:12];
        if (mode == MODE_ZERO) begin
            return {i12[11:5], idx[4:0], idx[4:0], 3'b010, i12[4:0], 7'b0100011};
        end
        case (mode)
            MODE_ALU:  sel = k % 4;
            MODE_CTRL: sel = (k % 4 == 0) ? 1 : 3 + k % 4;
            MODE_MEM:  sel = (k % 3 == 0) ? 1 : 6 + k % 3;
            default:   sel = k % 9;
        endcase
        case (sel)
            0: return {1'b0, r[18] && (f3 == 3'b000 || f3 == 3'b101), 5'd0,
                       rs2, rs1, f3, rd, 7'b0110011};
            1: begin
                if (f3 == 3'b001) begin
                    i12[11:5] = 7'd0;
                end else if (f3 == 3'b101) begin
                    i12[11:5] = {1'b0, r[18], 5'd0};
                end
                return {i12, rs1, f3, rd, 7'b0010011};
            end
            2: return {u20, rd, 7'b0110111};
            3: return {u20, rd, 7'b0010111};
            4: begin
                if (f3[2:1] == 2'b01) begin
                    f3[2] = 1'b1;
                end
                return {i12[11], i12[9:4], rs2, rs1, f3, i12[3:0], i12[10], 7'b1100011};
            end
            5: return {u20[19], u20[9:0], u20[10], u20[18:11], rd, 7'b1101111};
            6: return {i12, rs1, 3'b000, rd, 7'b1100111};
            7: begin
                if (f3 == 3'b011) begin
                    f3 = 3'b010;
                end else if (f3[2:1] == 2'b11) begin
                    f3[1] = 1'b0;
                end
                return {i12, rs1, f3, rd, 7'b0000011};
            end
            default: begin
                f3 = (r[16:15] == 2'b11) ? 3'b010 : {1'b0, r[16:15]};
                return {i12[11:5], rs2, rs1, f3, i12[4:0], 7'b0100011};
            end
        endcase
    endfunction

    task automatic end_test(input string name, input int count);
        run_tests++;
        total_errors += test_errors;
        if (test_errors != 0) begin
            failed_tests++;
            $display("%-14s %4d instructions, %0d errors", name, count, test_errors);
        end else begin
            $display("%-14s %4d instructions, ok", name, count);
        end
    endtask

    task automatic run_test(input string name, input int mode, input int count,
                            input int valid_pct, input int ready_pct,
                            input logic [4:0] reg_mask);
        int                issued;
        int                done;
        logic              fire;
        logic [31:0]       exp_instr;
        logic [31:0]       exp_pc;
        logic [31:0]       r;
        logic [4:0]        e_rd;
        logic              e_we;
        logic [31:0]       e_wdata;
        logic [31:0]       e_npc;
        logic [31:0]       e_addr;
        logic [31:0]       e_sdata;
        rv_pkg::mem_op_e   e_mem;
        issued      = 0;
        done        = 0;
        fire        = 1'b0;
        test_errors = 0;
        while (done < count) begin
            @(negedge I_clk);
            // A stalled request keeps its word and pc
            if (!in_valid || fire) begin
                if (issued < count && ($urandom % 100) < valid_pct) begin
                    r        = $urandom;
                    in_valid = 1'b1;
                    in_instr = make_instr(mode, issued, reg_mask);
                    in_pc    = {r[31:2], 2'b00};
                    issued++;
                end else begin
                    in_valid = 1'b0;
                end
            end
            out_ready = (($urandom % 100) < ready_pct);
            #1;
            fire = in_valid && in_ready;
            if (fire) begin
                instr_q.push_back(in_instr);
                pc_q.push_back(in_pc);
            end
            if (out_valid && out_ready) begin
                done++;
                if (instr_q.size() == 0) begin
                    $display("Error in %s: result delivered with no instruction in flight",
                             name);
                    test_errors++;
                end else begin
                    exp_instr = instr_q.pop_front();
                    exp_pc    = pc_q.pop_front();
                    run_model(exp_instr, exp_pc, e_rd, e_we, e_wdata, e_npc,
                              e_mem, e_addr, e_sdata);
                    check_reg(name, e_rd, e_we, out_rd, out_we);
                    if (e_we) begin
                        check_word(name, "wdata", e_wdata, out_wdata);
                    end
                    check_word(name, "next_pc", e_npc, out_next_pc);
                    check_mem(name, e_mem, out_mem_op);
                    if (e_mem != rv_pkg::mem_none) begin
                        check_word(name, "addr", e_addr, out_addr);
                    end
                    if (e_mem == rv_pkg::mem_wb || e_mem == rv_pkg::mem_wh ||
                        e_mem == rv_pkg::mem_ww) begin
                        check_word(name, "sdata", e_sdata, out_sdata);
                    end
                end
            end
        end
        // Drained pipeline must stay quiet
        repeat (3) begin
            @(negedge I_clk);
            in_valid  = 1'b0;
            out_ready = 1'b1;
            #1;
            if (out_valid) begin
                $display("Error in %s: extra result appeared after all were delivered", name);
                test_errors++;
            end
        end
        end_test(name, count);
    endtask

    initial begin
        in_valid     = 1'b0;
        in_instr     = 32'd0;
        in_pc        = 32'd0;
        out_ready    = 1'b0;
        rst          = 1'b1;
        total_errors = 0;
        failed_tests = 0;
        run_tests    = 0;
        void'($urandom(64));
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        repeat (16) @(posedge I_clk);
        @(negedge I_clk);
        rst = 1'b0;
        #1;
        test_errors = 0;
        if (out_valid || out_we) begin
            $display("Error in reset_state: result port active after reset");
            test_errors++;
        end
        if (!in_ready) begin
            $display("Error in reset_state: input not ready after reset");
            test_errors++;
        end
        end_test("reset_state", 0);

        run_test("zero_regs", MODE_ZERO, 32, 100, 100, 5'h1f);
        run_test("alu_ops", MODE_ALU, 300, 100, 100, 5'h1f);
        run_test("control", MODE_CTRL, 200, 90, 90, 5'h1f);
        run_test("memory", MODE_MEM, 200, 90, 90, 5'h1f);
        run_test("stall_mix", MODE_ALL, 300, 40, 35, 5'h1f);
        // Only four registers so most neighbours depend on each other
        run_test("dependent", MODE_ALL, 200, 100, 100, 5'h03);

        $display("Tests run %0d, tests failed %0d, check errors %0d",
                 run_tests, failed_tests, total_errors);
        if (failed_tests == 0 && total_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/rv_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_exec_core (
    input  wire                   I_clk,
    input  wire                   rst,
    input  wire                   in_valid,
    output logic                  in_ready,
    input  wire [31:0]            in_instr,
    input  wire [`RV_XLEN-1:0]    in_pc,
    output logic                  out_valid,
    input  wire                   out_ready,
    output logic [4:0]            out_rd,
    output logic                  out_we,
    output logic [`RV_XLEN-1:0]   out_wdata,
    output logic [`RV_XLEN-1:0]   out_next_pc,
    output rv_pkg::mem_op_e       out_mem_op,
    output logic [`RV_XLEN-1:0]   out_addr,
    output logic [`RV_XLEN-1:0]   out_sdata
);

    logic                   dec_valid;
    logic [`RV_XLEN-1:0]    dec_pc;
    logic [4:0]             dec_rs1;
    logic [4:0]             dec_rs2;
    logic [4:0]             dec_rd;
    logic [`RV_XLEN-1:0]    dec_imm;
    rv_pkg::mem_op_e        dec_mem_op;
    rv_pkg::alu_op_e        dec_alu_op;
    rv_pkg::op1_sel_e       dec_op1_sel;
    rv_pkg::op2_sel_e       dec_op2_sel;
    rv_pkg::wb_sel_e        dec_wb_sel;
    logic                   dec_wb_en;
    logic [5:0]             dec_branch_mask;
    logic                   dec_is_jal;
    logic                   dec_is_jalr;

    logic                   exec_advance;
    logic                   in_fire;
    logic [`RV_XLEN-1:0]    rdata1;
    logic [`RV_XLEN-1:0]    rdata2;
    logic [`RV_XLEN-1:0]    alu_a;
    logic [`RV_XLEN-1:0]    alu_b;
    logic [`RV_XLEN-1:0]    alu_y;
    logic [`RV_XLEN-1:0]    next_pc;
    logic [`RV_XLEN-1:0]    link;
    logic [`RV_XLEN-1:0]    wdata;
    logic                   rf_we;

    // Result register frees up when empty or being drained
    assign exec_advance = !out_valid || out_ready;
    assign in_ready     = !dec_valid || exec_advance;
    assign in_fire      = in_valid && in_ready;

    rv_decoder u_decoder (
        .I_clk       (I_clk),
        .en          (in_fire),
        .instr       (in_instr),
        .rs1         (dec_rs1),
        .rs2         (dec_rs2),
        .rd          (dec_rd),
        .imm         (dec_imm),
        .funct3      (),
        .mem_op      (dec_mem_op),
        .alu_op      (dec_alu_op),
        .op1_sel     (dec_op1_sel),
        .op2_sel     (dec_op2_sel),
        .wb_sel      (dec_wb_sel),
        .wb_en       (dec_wb_en),
        .branch_mask (dec_branch_mask),
        .is_jal      (dec_is_jal),
        .is_jalr     (dec_is_jalr)
    );

    always_ff @(posedge I_clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    // PC rides along with the decoder outputs
    always_ff @(posedge I_clk) begin
        if (in_fire) begin
            dec_pc <= in_pc;
        end
    end

    // Written on the same edge that loads the result register
    assign rf_we = exec_advance && dec_valid && dec_wb_en;

    rv_regfile u_regfile (
        .I_clk  (I_clk),
        .rst    (rst),
        .rs1    (dec_rs1),
        .rs2    (dec_rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (dec_rd),
        .wdata  (wdata)
    );

    assign alu_a = (dec_op1_sel == rv_pkg::op1_pc) ? dec_pc : rdata1;
    assign alu_b = (dec_op2_sel == rv_pkg::op2_imm) ? dec_imm : rdata2;

    rv_alu u_alu (
        .op (dec_alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    rv_branch_unit u_branch (
        .branch_mask (dec_branch_mask),
        .is_jal      (dec_is_jal),
        .is_jalr     (dec_is_jalr),
        .pc          (dec_pc),
        .imm         (dec_imm),
        .rs1_val     (rdata1),
        .rs2_val     (rdata2),
        .next_pc     (next_pc),
        .link        (link)
    );

    assign wdata = (dec_wb_sel == rv_pkg::wb_link) ? link : alu_y;

    // Control bits of the result register
    always_ff @(posedge I_clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_we    <= 1'b0;
        end else if (exec_advance) begin
            out_valid <= dec_valid;
            out_we    <= dec_valid && dec_wb_en;
        end
    end

    // Payload, loads and stores address through the ALU adder
    always_ff @(posedge I_clk) begin
        if (exec_advance) begin
            out_rd      <= dec_rd;
            out_wdata   <= wdata;
            out_next_pc <= next_pc;
            out_mem_op  <= dec_mem_op;
            out_addr    <= alu_y;
            out_sdata   <= rdata2;
        end
    end

endmodule

`default_nettype wire

/* hw/rv_branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_branch_unit (
    input  wire [5:0]             branch_mask,
    input  wire                   is_jal,
    input  wire                   is_jalr,
    input  wire [`RV_XLEN-1:0]    pc,
    input  wire [`RV_XLEN-1:0]    imm,
    input  wire [`RV_XLEN-1:0]    rs1_val,
    input  wire [`RV_XLEN-1:0]    rs2_val,
    output logic [`RV_XLEN-1:0]   next_pc,
    output logic [`RV_XLEN-1:0]   link
);

    logic                   eq;
    logic                   lt;
    logic                   ltu;
    logic                   taken;
    logic [`RV_XLEN-1:0]    jalr_sum;

    assign eq  = (rs1_val == rs2_val);
    assign lt  = ($signed(rs1_val) < $signed(rs2_val));
    assign ltu = (rs1_val < rs2_val);

    // Mask order is BEQ BNE BLT BGE BLTU BGEU from bit 0
    assign taken = |(branch_mask & {~ltu, ltu, ~lt, lt, ~eq, eq});

    assign jalr_sum = rs1_val + imm;
    assign link     = pc + 32'd4;

    always_comb begin
        if (taken || is_jal) begin
            next_pc = pc + imm;
        end else if (is_jalr) begin
            next_pc = {jalr_sum[`RV_XLEN-1:1], 1'b0};
        end else begin
            next_pc = link;
        end
    end

endmodule

`default_nettype wire

/* hw/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_alu (
    input  wire rv_pkg::alu_op_e  op,
    input  wire [`RV_XLEN-1:0]    a,
    input  wire [`RV_XLEN-1:0]    b,
    output logic [`RV_XLEN-1:0]   y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_pkg::alu_sub:
                y = a - b;
            rv_pkg::alu_sll:
                y = a << shamt;
            rv_pkg::alu_slt:
                y = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            rv_pkg::alu_sltu:
                y = {{(`RV_XLEN-1){1'b0}}, a < b};
            rv_pkg::alu_xor:
                y = a ^ b;
            rv_pkg::alu_srl:
                y = a >> shamt;
            // Arithmetic shift keeps the sign bit
            rv_pkg::alu_sra:
                y = $unsigned($signed(a) >>> shamt);
            rv_pkg::alu_or:
                y = a | b;
            rv_pkg::alu_and:
                y = a & b;
            default:
                y = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* hw/rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_regfile (
    input  wire                   I_clk,
    input  wire                   rst,
    input  wire [4:0]             rs1,
    input  wire [4:0]             rs2,
    output logic [`RV_XLEN-1:0]   rdata1,
    output logic [`RV_XLEN-1:0]   rdata2,
    input  wire                   we,
    input  wire [4:0]             waddr,
    input  wire [`RV_XLEN-1:0]    wdata
);

    logic [`RV_XLEN-1:0] regs [`RV_REGS];

    // x0 is hardwired on the read side
    assign rdata1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 : regs[rs2];

    always_ff @(posedge I_clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

`default_nettype wire

/* hw/rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_decoder (
    input  wire                   I_clk,
    input  wire                   en,
    input  wire [31:0]            instr,
    output logic [4:0]            rs1,
    output logic [4:0]            rs2,
    output logic [4:0]            rd,
    output logic [`RV_XLEN-1:0]   imm,
    output logic [2:0]            funct3,
    output rv_pkg::mem_op_e       mem_op,
    output rv_pkg::alu_op_e       alu_op,
    output rv_pkg::op1_sel_e      op1_sel,
    output rv_pkg::op2_sel_e      op2_sel,
    output rv_pkg::wb_sel_e       wb_sel,
    output logic                  wb_en,
    output logic [5:0]            branch_mask,
    output logic                  is_jal,
    output logic                  is_jalr
);

    logic [4:0]             opcode;
    logic [2:0]             f3;
    logic                   bit30;
    logic [`RV_XLEN-1:0]    imm_nxt;
    logic [4:0]             rs1_nxt;
    logic                   wb_en_nxt;
    logic [5:0]             mask_nxt;
    rv_pkg::alu_op_e        alu_nxt;
    rv_pkg::mem_op_e        mem_nxt;
    rv_pkg::op1_sel_e       op1_nxt;
    rv_pkg::op2_sel_e       op2_nxt;
    rv_pkg::wb_sel_e        wb_sel_nxt;

    assign opcode = instr[6:2];
    assign f3     = instr[14:12];
    assign bit30  = instr[30];

    // LUI runs as x0 + imm through the adder
    assign rs1_nxt = (opcode == `RV_OP_LUI) ? 5'd0 : instr[19:15];

    always_comb begin
        case (opcode)
            `RV_OP_STORE:
                imm_nxt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            `RV_OP_BRANCH:
                imm_nxt = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            `RV_OP_LUI, `RV_OP_AUIPC:
                imm_nxt = {instr[31:12], 12'd0};
            `RV_OP_JAL:
                imm_nxt = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                           instr[30:21], 1'b0};
            // I-type layout for all other opcodes
            default:
                imm_nxt = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_comb begin
        wb_en_nxt  = 1'b0;
        op1_nxt    = rv_pkg::op1_reg;
        op2_nxt    = rv_pkg::op2_imm;
        wb_sel_nxt = rv_pkg::wb_alu;
        case (opcode)
            `RV_OP_OP: begin
                wb_en_nxt = 1'b1;
                op2_nxt   = rv_pkg::op2_reg;
            end
            `RV_OP_OPIMM, `RV_OP_LUI:
                wb_en_nxt = 1'b1;
            `RV_OP_AUIPC: begin
                wb_en_nxt = 1'b1;
                op1_nxt   = rv_pkg::op1_pc;
            end
            `RV_OP_JAL: begin
                wb_en_nxt  = 1'b1;
                op1_nxt    = rv_pkg::op1_pc;
                wb_sel_nxt = rv_pkg::wb_link;
            end
            `RV_OP_JALR: begin
                wb_en_nxt  = 1'b1;
                wb_sel_nxt = rv_pkg::wb_link;
            end
            `RV_OP_BRANCH:
                op2_nxt = rv_pkg::op2_reg;
            // Loads, stores, SYSTEM and unknown opcodes write nothing
            default:
                wb_en_nxt = 1'b0;
        endcase
    end

    always_comb begin
        mask_nxt = 6'd0;
        if (opcode == `RV_OP_BRANCH) begin
            case (f3)
                `RV_F3_BEQ:  mask_nxt[0] = 1'b1;
                `RV_F3_BNE:  mask_nxt[1] = 1'b1;
                `RV_F3_BLT:  mask_nxt[2] = 1'b1;
                `RV_F3_BGE:  mask_nxt[3] = 1'b1;
                `RV_F3_BLTU: mask_nxt[4] = 1'b1;
                `RV_F3_BGEU: mask_nxt[5] = 1'b1;
                default:     mask_nxt = 6'd0;
            endcase
        end
    end

    always_comb begin
        alu_nxt = rv_pkg::alu_add;
        if (opcode == `RV_OP_OP || opcode == `RV_OP_OPIMM) begin
            case (f3)
                // Bit 30 selects SUB only for register-register ops
                `RV_F3_ADD:  alu_nxt = (bit30 && opcode == `RV_OP_OP) ?
                                       rv_pkg::alu_sub : rv_pkg::alu_add;
                `RV_F3_SLL:  alu_nxt = rv_pkg::alu_sll;
                `RV_F3_SLT:  alu_nxt = rv_pkg::alu_slt;
                `RV_F3_SLTU: alu_nxt = rv_pkg::alu_sltu;
                `RV_F3_XOR:  alu_nxt = rv_pkg::alu_xor;
                `RV_F3_SRL:  alu_nxt = bit30 ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                `RV_F3_OR:   alu_nxt = rv_pkg::alu_or;
                default:     alu_nxt = rv_pkg::alu_and;
            endcase
        end
    end

    always_comb begin
        mem_nxt = rv_pkg::mem_none;
        if (opcode == `RV_OP_LOAD) begin
            case (f3)
                `RV_F3_LB:  mem_nxt = rv_pkg::mem_rb;
                `RV_F3_LH:  mem_nxt = rv_pkg::mem_rh;
                `RV_F3_LW:  mem_nxt = rv_pkg::mem_rw;
                `RV_F3_LBU: mem_nxt = rv_pkg::mem_rbu;
                `RV_F3_LHU: mem_nxt = rv_pkg::mem_rhu;
                default:    mem_nxt = rv_pkg::mem_none;
            endcase
        end else if (opcode == `RV_OP_STORE) begin
            case (f3)
                `RV_F3_SB: mem_nxt = rv_pkg::mem_wb;
                `RV_F3_SH: mem_nxt = rv_pkg::mem_wh;
                `RV_F3_SW: mem_nxt = rv_pkg::mem_ww;
                default:   mem_nxt = rv_pkg::mem_none;
            endcase
        end
    end

    // Decode register holds while the stage is stalled
    always_ff @(posedge I_clk) begin
        if (en) begin
            rs1         <= rs1_nxt;
            rs2         <= instr[24:20];
            rd          <= instr[11:7];
            imm         <= imm_nxt;
            funct3      <= f3;
            mem_op      <= mem_nxt;
            alu_op      <= alu_nxt;
            op1_sel     <= op1_nxt;
            op2_sel     <= op2_nxt;
            wb_sel      <= wb_sel_nxt;
            wb_en       <= wb_en_nxt;
            branch_mask <= mask_nxt;
            is_jal      <= (opcode == `RV_OP_JAL);
            is_jalr     <= (opcode == `RV_OP_JALR);
        end
    end

endmodule

`default_nettype wire

/* hw/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // ALU operations
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // Memory request kinds, nine values so four bits
    typedef enum logic [3:0] {
        mem_none = 4'd0,
        mem_rb   = 4'd1,
        mem_rh   = 4'd2,
        mem_rw   = 4'd3,
        mem_rbu  = 4'd4,
        mem_rhu  = 4'd5,
        mem_wb   = 4'd6,
        mem_wh   = 4'd7,
        mem_ww   = 4'd8
    } mem_op_e;

    // First ALU operand
    typedef enum logic {
        op1_reg = 1'b0,
        op1_pc  = 1'b1
    } op1_sel_e;

    // Second ALU operand
    typedef enum logic {
        op2_reg = 1'b0,
        op2_imm = 1'b1
    } op2_sel_e;

    // Register write source
    typedef enum logic {
        wb_alu  = 1'b0,
        wb_link = 1'b1
    } wb_sel_e;

endpackage

`default_nettype wire

/* hw/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Datapath width and register count
`define RV_XLEN 32
`define RV_REGS 32

// Major opcodes, instr[6:2]
`define RV_OP_LOAD   5'b00000
`define RV_OP_STORE  5'b01000
`define RV_OP_BRANCH 5'b11000
`define RV_OP_JAL    5'b11011
`define RV_OP_JALR   5'b11001
`define RV_OP_OP     5'b01100
`define RV_OP_OPIMM  5'b00100
`define RV_OP_LUI    5'b01101
`define RV_OP_AUIPC  5'b00101
`define RV_OP_SYSTEM 5'b11100

// Branch funct3
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

// Load funct3
`define RV_F3_LB  3'b000
`define RV_F3_LH  3'b001
`define RV_F3_LW  3'b010
`define RV_F3_LBU 3'b100
`define RV_F3_LHU 3'b101

// Store funct3
`define RV_F3_SB 3'b000
`define RV_F3_SH 3'b001
`define RV_F3_SW 3'b010

// ALU funct3, shared by OP and OPIMM
`define RV_F3_ADD  3'b000
`define RV_F3_SLL  3'b001
`define RV_F3_SLT  3'b010
`define RV_F3_SLTU 3'b011
`define RV_F3_XOR  3'b100
`define RV_F3_SRL  3'b101
`define RV_F3_OR   3'b110
`define RV_F3_AND  3'b111

`endif
